// ==== common/soc_io_pkg.sv ====
package soc_io_pkg;

    localparam int unsigned DATA_W = 32;
    localparam int unsigned STRB_W = DATA_W / 8;
    localparam int unsigned BYTE_W = 8;
    localparam int unsigned BAUD_W = 16;

    // Device register map.
    localparam logic [DATA_W-1:0] UART_DATA_ADDR   = 32'h1001_0000;
    localparam logic [DATA_W-1:0] UART_STATUS_ADDR = 32'h1001_0005;
    localparam logic [DATA_W-1:0] BAUD_ADDR        = 32'h1001_0100;

    // One bit lasts divisor plus one cycles.
    localparam logic [BAUD_W-1:0] BAUD_RESET = 16'd3;

    localparam int unsigned MEM_WORDS = 256;
    localparam int unsigned MEM_AW    = $clog2(MEM_WORDS);

    // Flag positions in the line status byte.
    localparam int unsigned STATUS_BUSY_BIT  = 6;
    localparam int unsigned STATUS_READY_BIT = 0;

    typedef struct packed {
        logic [DATA_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wmask;
        logic              we;
        logic              re;
    } bus_req_t;

    typedef struct packed {
        logic busy;
        logic read_ready;
    } uart_status_t;

endpackage

// ==== design/data_memory.sv ====
`timescale 1ns/1ps

module data_memory import soc_io_pkg::*; (
    input  logic              clk,
    input  bus_req_t          req,
    input  logic              we,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [MEM_AW-1:0] word_idx;

    // Word index from the low address bits.
    assign word_idx = req.addr[MEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (req.wmask[b]) begin
                    mem[word_idx][b*BYTE_W +: BYTE_W] <= req.wdata[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    assign rdata = mem[word_idx];

endmodule

// ==== design/mmio_regs.sv ====
`timescale 1ns/1ps

module mmio_regs import soc_io_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  bus_req_t          req,
    input  logic [DATA_W-1:0] mem_rdata,
    output logic              mem_we,
    output logic              tx_start,
    output logic [BYTE_W-1:0] tx_byte,
    output logic [BAUD_W-1:0] baud_div,
    input  logic              rx_valid,
    input  logic [BYTE_W-1:0] rx_byte,
    output logic              rx_ack,
    input  uart_status_t      status,
    output logic [DATA_W-1:0] rdata
);

    logic              hit_data;
    logic              hit_baud;
    logic [BYTE_W-1:0] rx_hold;
    logic [BYTE_W-1:0] line_status;

    assign hit_data = (req.addr == UART_DATA_ADDR);
    assign hit_baud = (req.addr == BAUD_ADDR);

    // The data register has no memory alias on writes.
    assign mem_we = req.we && !hit_data;
    assign rx_ack = req.re && hit_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_start    <= 1'b0;
            tx_byte     <= '0;
            rx_hold     <= '0;
            line_status <= '0;
            baud_div    <= BAUD_RESET;
        end else begin
            tx_start <= req.we && hit_data; // Aligned with tx_byte.
            if (req.we && hit_data) begin
                tx_byte <= req.wdata[BYTE_W-1:0];
            end
            if (req.we && hit_baud) begin
                baud_div <= req.wdata[BAUD_W-1:0];
            end
            if (rx_valid) begin
                rx_hold <= rx_byte;
            end
            line_status                   <= '0;
            line_status[STATUS_BUSY_BIT]  <= status.busy;
            line_status[STATUS_READY_BIT] <= status.read_ready;
        end
    end

    // Read result back to the master.
    always_comb begin
        case (req.addr)
            UART_DATA_ADDR: begin
                rdata = {{(DATA_W-BYTE_W){1'b0}}, rx_hold};
            end
            UART_STATUS_ADDR: begin
                rdata = {{(DATA_W-BYTE_W){1'b0}}, line_status};
            end
            default: begin
                rdata = mem_rdata; // Everything else aliases into memory.
            end
        endcase
    end

endmodule

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx import soc_io_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [BYTE_W-1:0] data,
    input  logic [BAUD_W-1:0] baud_div,
    output logic              tx,
    output logic              busy
);

    logic [BYTE_W:0]   frame;
    logic [BAUD_W-1:0] baud_cnt;
    logic [3:0]        bit_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx       <= 1'b1;
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (start) begin
                tx       <= 1'b0; // Start bit.
                busy     <= 1'b1;
                baud_cnt <= baud_div;
                bit_cnt  <= '0;
            end
        end else if (baud_cnt != '0) begin
            baud_cnt <= baud_cnt - 1'b1;
        end else if (bit_cnt == 4'd9) begin
            // Stop bit has ended.
            tx   <= 1'b1;
            busy <= 1'b0;
        end else begin
            tx       <= frame[0];
            baud_cnt <= baud_div; // New divisor applies per bit.
            bit_cnt  <= bit_cnt + 1'b1;
        end
    end

    // Data bits LSB first, then the stop bit.
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            frame <= {1'b1, data};
        end else if (busy && baud_cnt == '0 && bit_cnt != 4'd9) begin
            frame <= {1'b1, frame[BYTE_W:1]};
        end
    end

endmodule

// ==== uart/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import soc_io_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx,
    input  logic [BAUD_W-1:0] baud_div,
    input  logic              ack,
    output logic              valid,
    output logic [BYTE_W-1:0] data,
    output logic              read_ready
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t         state;
    logic              rx_meta;
    logic              rx_sync;
    logic              rx_prev;
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_cnt;
    logic [BYTE_W-1:0] shift;

    // Two-flop synchronizer plus edge history.
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            valid    <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (rx_prev && !rx_sync) begin
                        state    <= RX_START;
                        baud_cnt <= baud_div >> 1; // Half a bit.
                    end
                end
                RX_START: begin
                    if (baud_cnt != '0) begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end else if (!rx_sync) begin
                        state    <= RX_DATA;
                        baud_cnt <= baud_div;
                        bit_cnt  <= '0;
                    end else begin
                        state <= RX_IDLE; // Glitch, not a start bit.
                    end
                end
                RX_DATA: begin
                    if (baud_cnt != '0) begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end else begin
                        baud_cnt <= baud_div;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (baud_cnt != '0) begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end else begin
                        state <= RX_IDLE;
                        valid <= rx_sync; // Low stop bit drops the frame.
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && baud_cnt == '0) begin
            shift <= {rx_sync, shift[BYTE_W-1:1]};
        end
    end

    assign data = shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            read_ready <= 1'b0;
        end else if (valid) begin
            read_ready <= 1'b1;
        end else if (ack) begin
            read_ready <= 1'b0;
        end
    end

endmodule

// ==== design/soc_io.sv ====
`timescale 1ns/1ps

module soc_io import soc_io_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  bus_req_t          req,
    output logic [DATA_W-1:0] rdata,
    output logic              tx,
    input  logic              rx
);

    logic [DATA_W-1:0] mem_rdata;
    logic              mem_we;
    logic              tx_start;
    logic [BYTE_W-1:0] tx_byte;
    logic [BAUD_W-1:0] baud_div;
    logic              rx_valid;
    logic [BYTE_W-1:0] rx_byte;
    logic              rx_ack;
    logic              tx_busy;
    logic              rx_ready;
    uart_status_t      status;

    assign status.busy       = tx_busy;
    assign status.read_ready = rx_ready;

    mmio_regs i_mmio_regs (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .mem_rdata (mem_rdata),
        .mem_we    (mem_we),
        .tx_start  (tx_start),
        .tx_byte   (tx_byte),
        .baud_div  (baud_div),
        .rx_valid  (rx_valid),
        .rx_byte   (rx_byte),
        .rx_ack    (rx_ack),
        .status    (status),
        .rdata     (rdata)
    );

    data_memory i_data_memory (
        .clk   (clk),
        .req   (req),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .start    (tx_start),
        .data     (tx_byte),
        .baud_div (baud_div),
        .tx       (tx),
        .busy     (tx_busy)
    );

    uart_rx i_uart_rx (
        .clk        (clk),
        .rst        (rst),
        .rx         (rx),
        .baud_div   (baud_div),
        .ack        (rx_ack),
        .valid      (rx_valid),
        .data       (rx_byte),
        .read_ready (rx_ready)
    );

endmodule

// ==== tests/soc_io_properties.sv ====
`timescale 1ns/1ps

module soc_io_properties (
    input logic clk,
    input logic rst,
    input logic tx,
    input logic busy,
    input logic tx_start,
    input logic rx_ack,
    input logic rx_valid,
    input logic read_ready
);

    int unsigned fail_count = 0;

    idle_line_high: assert property (@(posedge clk) disable iff (rst) !busy |-> tx)
        else begin
            fail_count++;
            $error("tx low while the transmitter is idle");
        end

    start_single: assert property (@(posedge clk) disable iff (rst) tx_start |=> !tx_start)
        else begin
            fail_count++;
            $error("tx_start high two cycles running");
        end

    ack_single: assert property (@(posedge clk) disable iff (rst) rx_ack |=> !rx_ack)
        else begin
            fail_count++;
            $error("rx_ack high two cycles running");
        end

    ready_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(read_ready) |-> $past(rx_valid))
        else begin
            fail_count++;
            $error("read_ready rose without rx_valid");
        end

    reset_state: assert property (@(posedge clk) $fell(rst) |-> (!busy && !read_ready))
        else begin
            fail_count++;
            $error("busy or read_ready set after reset");
        end

endmodule

bind soc_io soc_io_properties i_soc_io_properties (
    .clk        (clk),
    .rst        (rst),
    .tx         (tx),
    .busy       (tx_busy),
    .tx_start   (tx_start),
    .rx_ack     (rx_ack),
    .rx_valid   (rx_valid),
    .read_ready (rx_ready)
);

// ==== tests/soc_io_tb.sv ====
`timescale 1ns/1ps

module soc_io_tb import soc_io_pkg::*; ();

    localparam int LIMIT = 4000;
    localparam logic [31:0] STATUS_MASK = (32'd1 << STATUS_BUSY_BIT) |
                                          (32'd1 << STATUS_READY_BIT);

    logic        clk;
    logic        rst;
    bus_req_t    req;
    logic [31:0] rdata;
    logic        serial;
    logic [31:0] lfsr;
    logic [31:0] mem_model [MEM_WORDS];
    int          errors;
    int          bit_cycles;

    // Serial line looped back onto the receiver.
    soc_io i_soc_io (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .rdata (rdata),
        .tx    (serial),
        .rx    (serial)
    );

    always #4 clk = ~clk;

    // Only the busy and ready flags may be set in the status word.
    status_bits: assert property (@(posedge clk) disable iff (rst)
        (req.re && req.addr == UART_STATUS_ADDR) |-> ((rdata & ~STATUS_MASK) == '0))
        else begin
            errors++;
            $display("[FAIL] %0t rdata extra bits %h expected %h", $time,
                     $sampled(rdata) & ~STATUS_MASK, 32'h0);
        end

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1; // Galois step.
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] mask);
        @(posedge clk);
        #1;
        req = '{addr: addr, wdata: data, wmask: mask, we: 1'b1, re: 1'b0};
        @(posedge clk);
        #1;
        req = '0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        req = '{addr: addr, wdata: '0, wmask: '0, we: 1'b0, re: 1'b1};
        #2;
        data = rdata; // Combinational read.
        @(posedge clk);
        #1;
        req = '0;
    endtask

    task automatic wait_status(input int pos, input logic value, input string what);
        logic [31:0] st;
        bit          seen;
        seen = 0;
        for (int i = 0; i < LIMIT && !seen; i++) begin
            bus_read(UART_STATUS_ADDR, st);
            seen = (st[pos] == value);
        end
        if (!seen) begin
            errors++;
            $display("Timeout at %0t while waiting for %s", $time, what);
        end
    endtask

    task automatic wait_tx_low();
        bit seen;
        seen = 0;
        for (int i = 0; i < LIMIT && !seen; i++) begin
            @(posedge clk);
            #1;
            seen = !serial;
        end
        if (!seen) begin
            errors++;
            $display("Timeout at %0t while waiting for a start bit on tx", $time);
        end
    endtask

    // Samples each bit in its middle.
    task automatic check_frame(input logic [7:0] value);
        logic [9:0] bits;
        bits = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            if (i == 0) begin
                repeat (bit_cycles / 2) @(posedge clk);
            end else begin
                repeat (bit_cycles) @(posedge clk);
            end
            #1;
            check_value($sformatf("tx bit %0d", i), serial, bits[i]);
        end
    endtask

    task automatic send_frame(input logic [7:0] value, input bit inject,
                              input logic [7:0] extra);
        logic [31:0] st;
        bus_write(UART_DATA_ADDR, {24'h0, value}, 4'h1);
        wait_tx_low();
        fork
            check_frame(value);
            begin
                repeat (2 * bit_cycles) @(posedge clk);
                bus_read(UART_STATUS_ADDR, st);
                check_value("status busy", st[STATUS_BUSY_BIT], 1'b1);
                if (inject) begin
                    bus_write(UART_DATA_ADDR, {24'h0, extra}, 4'h1); // Lands while busy.
                end
            end
        join
    endtask

    task automatic check_receive(input logic [7:0] value);
        logic [31:0] rd;
        wait_status(STATUS_BUSY_BIT, 1'b0, "busy to clear");
        wait_status(STATUS_READY_BIT, 1'b1, "read ready");
        bus_read(UART_DATA_ADDR, rd);
        check_value("rx data", rd, {24'h0, value});
        bus_read(UART_STATUS_ADDR, rd);
        check_value("status ready", rd[STATUS_READY_BIT], 1'b0);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] data;
        logic [7:0]  idx;
        logic [3:0]  mask;
        logic [7:0]  sent;
        clk        = 1'b0;
        rst        = 1'b1;
        req        = '0;
        lfsr       = 32'h214;
        errors     = 0;
        bit_cycles = BAUD_RESET + 1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        bus_read(UART_STATUS_ADDR, rd);
        check_value("status", rd, 32'h0);
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            #1;
            check_value("tx idle", serial, 1'b1);
        end

        // Fill every word first, then merge masked writes.
        for (int i = 0; i < MEM_WORDS; i++) begin
            data         = random_bits(32);
            mem_model[i] = data;
            bus_write(i << 2, data, 4'hF);
        end
        for (int n = 0; n < 64; n++) begin
            idx  = 8'(random_bits(8));
            mask = 4'(random_bits(4));
            data = random_bits(32);
            bus_write({22'h0, idx, 2'b00}, data, mask);
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    mem_model[idx][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            bus_read(i << 2, rd);
            check_value($sformatf("mem word %0d", i), rd, mem_model[i]);
        end

        sent = 8'(random_bits(8));
        send_frame(sent, 1'b0, 8'h00);
        check_receive(sent);

        bus_write(BAUD_ADDR, 32'd7, 4'hF);
        bit_cycles = 8;
        repeat (4) begin
            sent = 8'(random_bits(8));
            send_frame(sent, 1'b0, 8'h00);
            check_receive(sent);
        end

        sent = 8'(random_bits(8));
        send_frame(sent, 1'b1, ~sent);
        check_receive(sent);
        for (int i = 0; i < 12 * bit_cycles; i++) begin
            @(posedge clk);
            #1;
            check_value("tx after drop", serial, 1'b1);
        end
        bus_read(UART_STATUS_ADDR, rd);
        check_value("status after drop", rd, 32'h0);

        repeat (4) @(posedge clk);
        $display("Done: %0d check errors, %0d assertion errors", errors,
                 i_soc_io.i_soc_io_properties.fail_count);
        if (errors == 0 && i_soc_io.i_soc_io_properties.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== project.f ====
common/soc_io_pkg.sv
design/data_memory.sv
design/mmio_regs.sv
uart/uart_tx.sv
uart/uart_rx.sv
design/soc_io.sv
tests/soc_io_properties.sv
tests/soc_io_tb.sv

// ==== Bender.yml ====
package:
  name: soc_io

sources:
  - common/soc_io_pkg.sv
  - design/data_memory.sv
  - design/mmio_regs.sv
  - uart/uart_tx.sv
  - uart/uart_rx.sv
  - design/soc_io.sv
  - target: test
    files:
      - tests/soc_io_properties.sv
      - tests/soc_io_tb.sv
